//--- hw/bch_pkg.sv
package bch_pkg;

	// GF(2^4) field and BCH(15,7) code constants
	localparam int gf_m   = 4;
	localparam int code_n = 15; // also the multiplicative order of alpha
	localparam int code_k = 7;

	// x^4 + x + 1
	localparam logic [gf_m:0] gf_poly = 5'b10011;

	typedef logic [gf_m-1:0] gf_t;

	// polynomial-basis multiply that shifts and reduces one bit at a time
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t prod;
		gf_t shifted;
		prod = '0;
		shifted = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				prod ^= shifted;
			// multiply by x and fold x^4 back in with the low bits of the polynomial
			if (shifted[gf_m-1])
				shifted = (shifted << 1) ^ gf_poly[gf_m-1:0];
			else
				shifted = shifted << 1;
		end
		return prod;
	endfunction

	// alpha^e with the exponent taken modulo the field order
	function automatic gf_t gf_alpha_pow(int e);
		int   r;
		gf_t  val;
		r = e % code_n;
		if (r < 0)
			r += code_n;
		val = gf_t'(1);
		for (int i = 0; i < r; i++)
			val = gf_mul(val, gf_t'(2)); // alpha is x
		return val;
	endfunction

	/*
	 * squaring is linear over GF(2), so it reduces to a fixed XOR network
	 * (a0 + a1 x + a2 x^2 + a3 x^3)^2 = a0 + a1 x^2 + a2 x^4 + a3 x^6
	 * with x^4 = x + 1 and x^6 = x^3 + x^2
	 */
	function automatic gf_t gf_sqr(gf_t a);
		gf_t sq;
		sq[0] = a[0] ^ a[2];
		sq[1] = a[2];
		sq[2] = a[1] ^ a[3];
		sq[3] = a[3];
		return sq;
	endfunction

endpackage

//--- hw/bch_syndrome_top.sv
`timescale 1ns/1ps

/*
 * BCH(15,7) t=2 syndrome calculator
 * received word streamed in BITS coefficients per beat, S1..S4 and err returned
 */
module bch_syndrome_top #(
	parameter int BITS = 5 // must divide 15
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_req,
	input  logic [BITS-1:0] in_data,
	output logic            in_ack,
	output logic            out_req,
	input  logic            out_ack,
	output bch_pkg::gf_t    syn1,
	output bch_pkg::gf_t    syn2,
	output bch_pkg::gf_t    syn3,
	output bch_pkg::gf_t    syn4,
	output logic            err
);

	logic            step;
	logic            first;
	logic [BITS-1:0] beat_data;
	bch_pkg::gf_t    acc_s1;
	bch_pkg::gf_t    acc_s3;

	codeword_sequencer #(
		.BITS(BITS)
	) u_seq (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_req    (in_req),
		.in_data   (in_data),
		.in_ack    (in_ack),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.step      (step),
		.first     (first),
		.beat_data (beat_data)
	);

	// odd syndromes both fed by the same beat
	syndrome_unit #(
		.BITS    (BITS),
		.SYN_IDX (1)
	) u_syn1 (
		.clk       (clk),
		.arst_n    (arst_n),
		.step      (step),
		.first     (first),
		.beat_data (beat_data),
		.syn       (acc_s1)
	);

	syndrome_unit #(
		.BITS    (BITS),
		.SYN_IDX (3)
	) u_syn3 (
		.clk       (clk),
		.arst_n    (arst_n),
		.step      (step),
		.first     (first),
		.beat_data (beat_data),
		.syn       (acc_s3)
	);

	syndrome_expand u_expand (
		.syn1_in (acc_s1),
		.syn3_in (acc_s3),
		.syn1    (syn1),
		.syn2    (syn2),
		.syn3    (syn3),
		.syn4    (syn4),
		.err     (err)
	);

endmodule

//--- hw/codeword_sequencer.sv
`timescale 1ns/1ps

/*
 * input and result four-phase handshakes
 *
 * accept edge    in_ack rises, beat_data captured
 * next cycle     step high (first with beat 0)
 * end of step    syndrome units update, out_req rises after the last beat
 */
module codeword_sequencer #(
	parameter int BITS = 5
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_req,
	input  logic [BITS-1:0] in_data,
	output logic            in_ack,
	output logic            out_req,
	input  logic            out_ack,
	output logic            step,
	output logic            first,
	output logic [BITS-1:0] beat_data
);

	localparam int beats = bch_pkg::code_n / BITS;
	localparam int cnt_w = (beats > 1) ? $clog2(beats) : 1;

	logic [cnt_w-1:0] beat_cnt;
	logic             got_beat;  // accepted last edge so step follows
	logic             out_wait;  // out_req dropped and out_ack not yet low
	logic             res_busy;
	logic             accept;
	logic             last_beat;

	assign res_busy  = out_req | out_wait;
	// a beat still in flight also holds off the next one
	assign accept    = in_req & ~in_ack & ~res_busy & ~got_beat & ~step;
	assign last_beat = (beat_cnt == cnt_w'(beats - 1));

	// copy of the accepted beat
	always_ff @(posedge clk) begin
		if (accept)
			beat_data <= in_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_ack   <= 1'b0;
			got_beat <= 1'b0;
			step     <= 1'b0;
			first    <= 1'b0;
			beat_cnt <= '0;
			out_req  <= 1'b0;
			out_wait <= 1'b0;
		end else begin
			// input side
			if (accept)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0;

			got_beat <= accept;
			step     <= got_beat;
			first    <= got_beat && (beat_cnt == '0);

			// word completes at the end of the last step
			if (step) begin
				beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
				if (last_beat)
					out_req <= 1'b1;
			end

			// result side
			if (out_req && out_ack) begin
				out_req  <= 1'b0;
				out_wait <= 1'b1;
			end else if (out_wait && !out_ack) begin
				out_wait <= 1'b0;
			end
		end
	end

endmodule

//--- hw/syndrome_expand.sv
`timescale 1ns/1ps

/*
 * even syndromes of a binary code come for free
 * S_2j = r(alpha^2j) = r(alpha^j)^2 since r has coefficients in GF(2)
 * so S2 = S1^2 and S4 = S2^2
 */
module syndrome_expand (
	input  bch_pkg::gf_t syn1_in,
	input  bch_pkg::gf_t syn3_in,
	output bch_pkg::gf_t syn1,
	output bch_pkg::gf_t syn2,
	output bch_pkg::gf_t syn3,
	output bch_pkg::gf_t syn4,
	output logic         err
);

	bch_pkg::gf_t s2;
	bch_pkg::gf_t s4;

	assign s2 = bch_pkg::gf_sqr(syn1_in);
	assign s4 = bch_pkg::gf_sqr(s2); // S1^4

	assign syn1 = syn1_in;
	assign syn2 = s2;
	assign syn3 = syn3_in;
	assign syn4 = s4;

	// S2 and S4 are zero exactly when S1 is, so the odd ones decide the flag
	assign err = |{syn1_in, syn3_in};

endmodule

//--- hw/syndrome_unit.sv
`timescale 1ns/1ps

/*
 * Horner accumulator for one odd syndrome S_j = r(alpha^j)
 *
 * each beat carries BITS coefficients, highest degree in the top bit
 * per step
 *   acc = acc * alpha^(j*BITS) + sum_b r_b * alpha^(j*b)
 * the last beat holds degrees BITS-1 down to 0, so after it acc = r(alpha^j)
 */
module syndrome_unit #(
	parameter int BITS    = 5,
	parameter int SYN_IDX = 1
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             step,      // one update per strobe
	input  logic             first,     // beat 0 starts from an empty accumulator
	input  logic [BITS-1:0]  beat_data,
	output bch_pkg::gf_t     syn
);

	// multiplier applied to the running value once per beat
	localparam bch_pkg::gf_t beat_factor = bch_pkg::gf_alpha_pow(SYN_IDX * BITS);

	bch_pkg::gf_t terms   [BITS];   // weight masked by the received bit
	bch_pkg::gf_t term_sum;
	bch_pkg::gf_t acc_prev;
	bch_pkg::gf_t acc_scaled;
	bch_pkg::gf_t syn_next;

	/*
	 * slot i counts from the top of the beat, so slot 0 is beat_data[BITS-1]
	 * and carries the highest degree of the beat
	 */
	for (genvar i = 0; i < BITS; i++) begin : g_terms
		localparam bch_pkg::gf_t slot_pow = bch_pkg::gf_alpha_pow(SYN_IDX * (BITS - 1 - i));

		assign terms[i] = beat_data[BITS-1-i] ? slot_pow : '0;
	end

	// GF(2) addition of all the bit terms
	always_comb begin
		term_sum = '0;
		for (int i = 0; i < BITS; i++)
			term_sum ^= terms[i];
	end

	assign acc_prev   = first ? '0 : syn; // drops whatever an earlier word left behind
	assign acc_scaled = bch_pkg::gf_mul(acc_prev, beat_factor);
	assign syn_next   = acc_scaled ^ term_sum;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			syn <= '0;
		end else if (step) begin
			syn <= syn_next;
		end
	end

endmodule

//--- project.f
hw/bch_pkg.sv
hw/syndrome_unit.sv
hw/codeword_sequencer.sv
hw/syndrome_expand.sv
hw/bch_syndrome_top.sv
testbench/tb_bch_syndrome_sva.sv
testbench/tb_bch_syndrome.sv

//--- run_sim.sh
#!/bin/sh
# build and run the BCH syndrome testbench with Verilator
# the exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_bch_syndrome \
	-Mdir obj_dir

./obj_dir/Vtb_bch_syndrome

//--- testbench/tb_bch_syndrome.sv
`timescale 1ns/1ps

module tb_bch_syndrome;

	localparam int bits     = 5;
	localparam int beats    = bch_pkg::code_n / bits;
	localparam int wait_max = 100; // cycles before a handshake wait gives up
	localparam int n_rows   = 10;
	localparam int n_random = 24;
	localparam int no_err   = 15;  // marks an unused error slot

	// codewords are multiples of g = x^8 + x^7 + x^6 + x^4 + 1 (0x1d1)
	// each row holds a codeword, two error positions and the expected err flag
	localparam logic [14:0] tbl_word [n_rows] = '{
		15'h0000, 15'h01d1, 15'h0273, 15'h7440, 15'h7fff,
		15'h01d1, 15'h0000, 15'h7440, 15'h03a2, 15'h7fff
	};
	localparam int tbl_e1 [n_rows] = '{15, 15, 15, 15, 15, 0, 14, 3, 7, 2};
	localparam int tbl_e2 [n_rows] = '{15, 15, 15, 15, 15, 15, 15, 11, 8, 13};
	localparam logic tbl_err [n_rows] = '{0, 0, 0, 0, 0, 1, 1, 1, 1, 1};

	logic            clk;
	logic            arst_n;
	logic            in_req;
	logic [bits-1:0] in_data;
	logic            in_ack;
	logic            out_req;
	logic            out_ack;
	bch_pkg::gf_t    syn1;
	bch_pkg::gf_t    syn2;
	bch_pkg::gf_t    syn3;
	bch_pkg::gf_t    syn4;
	logic            err;

	bch_pkg::gf_t    gf_exp [15]; // alpha^i built from its own x^4 + x + 1 reduction
	logic [31:0]     lfsr_state;

	bch_syndrome_top #(
		.BITS(bits)
	) u_dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_req  (in_req),
		.in_data (in_data),
		.in_ack  (in_ack),
		.out_req (out_req),
		.out_ack (out_ack),
		.syn1    (syn1),
		.syn2    (syn2),
		.syn3    (syn3),
		.syn4    (syn4),
		.err     (err)
	);

	always #20 clk = ~clk;

	// right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic build_exp_table();
		logic [4:0] v;
		v = 5'd1;
		for (int i = 0; i < 15; i++) begin
			gf_exp[i] = v[3:0];
			v = v << 1;
			if (v[4])
				v = v ^ 5'b10011; // x^4 = x + 1
		end
	endtask

	// S_j = r(alpha^j) packed as {S4, S3, S2, S1}
	function automatic logic [15:0] ref_syndromes(logic [14:0] word);
		logic [15:0] s;
		s = '0;
		for (int j = 1; j <= 4; j++)
			for (int i = 0; i < 15; i++)
				if (word[i])
					s[(j-1)*4 +: 4] ^= gf_exp[(i * j) % 15];
		return s;
	endfunction

	// a codeword contributes nothing so only the error positions remain
	function automatic logic [15:0] err_syndromes(int e1, int e2);
		logic [15:0] s;
		s = '0;
		for (int j = 1; j <= 4; j++) begin
			if (e1 != no_err)
				s[(j-1)*4 +: 4] ^= gf_exp[(j * e1) % 15];
			if (e2 != no_err)
				s[(j-1)*4 +: 4] ^= gf_exp[(j * e2) % 15];
		end
		return s;
	endfunction

	function automatic logic [14:0] error_mask(int e1, int e2);
		logic [14:0] m;
		m = '0;
		if (e1 != no_err)
			m[e1] = 1'b1;
		if (e2 != no_err)
			m[e2] = 1'b1;
		return m;
	endfunction

	task automatic check_syn(input string name, input bch_pkg::gf_t actual,
			input bch_pkg::gf_t expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at mismatch on %s", name);
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s did not happen within %0d cycles", what, wait_max);
		$display("Verification failed");
		$fatal(1, "handshake timeout");
	endtask

	task automatic check_results(input logic [15:0] expected, input logic exp_err);
		check_syn("syn1", syn1, expected[3:0]);
		check_syn("syn2", syn2, expected[7:4]);
		check_syn("syn3", syn3, expected[11:8]);
		check_syn("syn4", syn4, expected[15:12]);
		check_flag("err", err, exp_err);
	endtask

	// values are read at the edge, before that edge's updates land
	task automatic wait_in_ack(input logic level);
		int n;
		n = 0;
		@(posedge clk);
		while (in_ack !== level) begin
			n++;
			if (n > wait_max)
				report_timeout($sformatf("in_ack going to %0d", level));
			@(posedge clk);
		end
	endtask

	// with guard set a new beat is pending and in_ack must stay low meanwhile
	task automatic wait_out_req(input logic level, input logic guard);
		int n;
		n = 0;
		@(posedge clk);
		while (out_req !== level) begin
			if (guard)
				check_flag("in_ack", in_ack, 1'b0);
			n++;
			if (n > wait_max)
				report_timeout($sformatf("out_req going to %0d", level));
			@(posedge clk);
		end
		if (guard)
			check_flag("in_ack", in_ack, 1'b0);
	endtask

	task automatic send_beat(input logic [bits-1:0] d);
		@(posedge clk);
		in_data <= d;
		in_req  <= 1'b1;
		wait_in_ack(1'b1);
		in_req  <= 1'b0;
		wait_in_ack(1'b0);
	endtask

	task automatic send_word(input logic [14:0] w);
		for (int k = 0; k < beats; k++)
			send_beat(w[bch_pkg::code_n - (k + 1) * bits +: bits]);
	endtask

	task automatic collect_result(input logic [15:0] expected, input logic exp_err,
			input int delay, input logic guard);
		wait_out_req(1'b1, guard);
		check_results(expected, exp_err);
		repeat (delay) begin
			@(posedge clk);
			check_flag("out_req", out_req, 1'b1);
			if (guard)
				check_flag("in_ack", in_ack, 1'b0);
			check_results(expected, exp_err); // must hold until out_ack
		end
		out_ack <= 1'b1;
		wait_out_req(1'b0, guard);
		out_ack <= 1'b0;
	endtask

	task automatic run_word(input logic [14:0] w, input logic [15:0] expected,
			input logic exp_err, input int delay);
		send_word(w);
		collect_result(expected, exp_err, delay, 1'b0);
	endtask

	// second word's first beat is offered while the first result is still out
	task automatic run_backpressure(input logic [14:0] a, input logic [14:0] b,
			input int delay);
		logic [15:0] syn_a;
		logic [15:0] syn_b;
		syn_a = ref_syndromes(a);
		syn_b = ref_syndromes(b);
		send_word(a);
		@(posedge clk);
		in_data <= b[bch_pkg::code_n - bits +: bits];
		in_req  <= 1'b1;
		collect_result(syn_a, |syn_a, delay, 1'b1);
		wait_in_ack(1'b1);
		in_req <= 1'b0;
		wait_in_ack(1'b0);
		for (int k = 1; k < beats; k++)
			send_beat(b[bch_pkg::code_n - (k + 1) * bits +: bits]);
		collect_result(syn_b, |syn_b, 0, 1'b0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (4) @(posedge clk);
		check_flag("in_ack", in_ack, 1'b0);
		check_flag("out_req", out_req, 1'b0);
		arst_n <= 1'b1;
		@(posedge clk);
		check_flag("in_ack", in_ack, 1'b0);
		check_flag("out_req", out_req, 1'b0);
	endtask

	initial begin
		logic [31:0] v;
		logic [14:0] w;
		logic [14:0] w2;
		logic [15:0] syn_ref;
		int          d;

		clk        = 1'b0;
		arst_n     = 1'b0;
		in_req     = 1'b0;
		in_data    = '0;
		out_ack    = 1'b0;
		lfsr_state = 32'd81557;
		build_exp_table();
		apply_reset();

		for (int r = 0; r < n_rows; r++) begin
			w = tbl_word[r] ^ error_mask(tbl_e1[r], tbl_e2[r]);
			run_word(w, err_syndromes(tbl_e1[r], tbl_e2[r]), tbl_err[r], r % 3);
		end

		for (int r = 0; r < n_random; r++) begin
			take_bits(15, v);
			w = v[14:0];
			take_bits(2, v);
			d = int'(v[1:0]);
			syn_ref = ref_syndromes(w);
			run_word(w, syn_ref, |syn_ref, d);
		end

		for (int r = 0; r < 4; r++) begin
			take_bits(15, v);
			w = v[14:0];
			take_bits(15, v);
			w2 = v[14:0];
			run_backpressure(w, w2, r * 3);
		end

		// abandon a word after two beats and then send a full word
		take_bits(15, v);
		w = v[14:0];
		send_beat(w[14:10]);
		send_beat(w[9:5]);
		apply_reset();
		take_bits(15, v);
		w2 = v[14:0];
		syn_ref = ref_syndromes(w2);
		run_word(w2, syn_ref, |syn_ref, 1);

		$display("Verification passed");
		$finish;
	end

endmodule

//--- testbench/tb_bch_syndrome_sva.sv
`timescale 1ns/1ps

module tb_bch_syndrome_sva (
	input logic         clk,
	input logic         arst_n,
	input logic         in_req,
	input logic         in_ack,
	input logic         out_req,
	input logic         out_ack,
	input bch_pkg::gf_t syn1,
	input bch_pkg::gf_t syn2,
	input bch_pkg::gf_t syn3,
	input bch_pkg::gf_t syn4,
	input logic         err
);

	// ack only answers a pending request
	a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without in_req");

	// result is withdrawn only once the host took it
	a_req_drop_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(out_req) |-> $past(out_ack))
		else $error("out_req fell before out_ack was seen");

	a_result_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(out_req && $past(out_req)) |-> $stable({syn1, syn2, syn3, syn4, err}))
		else $error("result changed while out_req was high");

endmodule

bind bch_syndrome_top tb_bch_syndrome_sva u_sva (
	.clk     (clk),
	.arst_n  (arst_n),
	.in_req  (in_req),
	.in_ack  (in_ack),
	.out_req (out_req),
	.out_ack (out_ack),
	.syn1    (syn1),
	.syn2    (syn2),
	.syn3    (syn3),
	.syn4    (syn4),
	.err     (err)
);
